//--- hdl/rv32i_pkg.sv
package rv32i_pkg;

    // datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int FMT_W    = 3;

    typedef logic [XLEN-1:0]       rv32i_word_t;
    typedef logic [REG_ADDR_W-1:0] rv32i_reg_t;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [OPCODE_W-1:0] {
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_jalr     = 7'b1100111,
        opc_branch   = 7'b1100011,
        opc_load     = 7'b0000011,
        opc_store    = 7'b0100011,
        opc_op_imm   = 7'b0010011,
        opc_op       = 7'b0110011,
        opc_misc_mem = 7'b0001111,
        opc_system   = 7'b1110011
    } rv32i_opcode_e;

    // base instruction formats
    typedef enum logic [FMT_W-1:0] {
        fmt_r = 3'd0,
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } inst_fmt_e;

    // one decoded instruction with its operands, 132 bits
    typedef struct packed {
        rv32i_opcode_e         opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic [FUNCT7_W-1:0]   funct7;
        rv32i_reg_t            rs1;
        rv32i_reg_t            rs2;
        rv32i_reg_t            rd;
        rv32i_word_t           rs1_data;
        rv32i_word_t           rs2_data;
        rv32i_word_t           imm;
        inst_fmt_e             fmt;
        logic                  illegal;
    } decoded_t;

    // register write from the later stages, 38 bits
    typedef struct packed {
        logic        load;
        rv32i_reg_t  rd;
        rv32i_word_t data;
    } wb_t;

endpackage : rv32i_pkg

//--- hdl/decode_skid_buffer.sv
module decode_skid_buffer #(
    parameter type payload_t = rv32i_pkg::rv32i_word_t
) (
    input  logic     clk,
    input  logic     rst_n_i,

    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,

    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    payload_t main_q;
    payload_t skid_q;
    logic     main_valid_q;
    logic     skid_valid_q;
    logic     push;
    logic     pop;

    // ready only depends on the skid flop
    assign in_ready_o  = ~skid_valid_q;
    assign out_valid_o = main_valid_q;
    assign out_data_o  = main_q;

    assign push = in_valid_i & in_ready_o;
    assign pop  = main_valid_q & out_ready_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end
        else if (skid_valid_q)
        begin
            // skid entry moves up and main stays valid
            if (pop)
            begin
                skid_valid_q <= 1'b0;
            end
        end
        else if (push)
        begin
            if (main_valid_q && !pop)
            begin
                skid_valid_q <= 1'b1;
            end
            else
            begin
                main_valid_q <= 1'b1;
            end
        end
        else if (pop)
        begin
            main_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (skid_valid_q)
        begin
            if (pop)
            begin
                main_q <= skid_q;
            end
        end
        else if (push)
        begin
            // main entry stalled so the new beat parks in the skid slot
            if (main_valid_q && !pop)
            begin
                skid_q <= in_data_i;
            end
            else
            begin
                main_q <= in_data_i;
            end
        end
    end

    // a stalled beat holds its value until taken
    a_out_stable : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o))
    ) else $error("skid buffer output changed while stalled");

    // a full buffer keeps its parked beat until the head is taken
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (main_valid_q && skid_valid_q && !pop) |=> (skid_valid_q && $stable(skid_q))
    ) else $error("skid buffer accepted a beat while full");

endmodule : decode_skid_buffer

//--- hdl/regfile.sv
module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  rv32i_pkg::wb_t         wb_i,

    input  rv32i_pkg::rv32i_reg_t  rs1_i,
    input  rv32i_pkg::rv32i_reg_t  rs2_i,
    output rv32i_pkg::rv32i_word_t rs1_data_o,
    output rv32i_pkg::rv32i_word_t rs2_data_o
);

    // x0 has no storage
    rv32i_pkg::rv32i_word_t regs_q [1:rv32i_pkg::NUM_REGS-1];
    logic                   wr_en;

    assign wr_en = wb_i.load && (wb_i.rd != '0);

    // one read port with write-to-read bypass
    function automatic rv32i_pkg::rv32i_word_t read_port(
        input rv32i_pkg::rv32i_reg_t addr
    );
        rv32i_pkg::rv32i_word_t value;
        if (addr == '0)
        begin
            value = '0;
        end
        else if (wr_en && (wb_i.rd == addr))
        begin
            value = wb_i.data;
        end
        else
        begin
            value = regs_q[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            for (int i = 1; i < rv32i_pkg::NUM_REGS; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb
    begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    // a read in the cycle after a write-back sees the new value and x0 still reads zero
    a_wb_readback : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_i.load ##1 ((rs1_i == $past(wb_i.rd)) && !wr_en))
            |-> (rs1_data_o == ((rs1_i == '0) ? '0 : $past(wb_i.data)))
    ) else $error("register read after a write-back returned a wrong value");

endmodule : regfile

//--- hdl/decode_stage.sv
module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  rv32i_pkg::wb_t         wb_i,

    input  logic                   in_valid_i,
    input  rv32i_pkg::rv32i_word_t instr_i,
    output logic                   in_ready_o,

    output logic                   out_valid_o,
    output rv32i_pkg::decoded_t    pkt_o,
    input  logic                   out_ready_i
);

    rv32i_pkg::rv32i_opcode_e              opcode;
    logic [rv32i_pkg::FUNCT3_W-1:0]        funct3;
    logic [rv32i_pkg::FUNCT7_W-1:0]        funct7;
    rv32i_pkg::rv32i_reg_t                 rs1;
    rv32i_pkg::rv32i_reg_t                 rs2;
    rv32i_pkg::rv32i_reg_t                 rd;
    rv32i_pkg::rv32i_word_t                rs1_data;
    rv32i_pkg::rv32i_word_t                rs2_data;
    rv32i_pkg::rv32i_word_t                imm;
    rv32i_pkg::inst_fmt_e                  fmt;
    logic                                  illegal;

    // stage is combinational, handshake passes straight through
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;

    // fixed field positions
    assign opcode = rv32i_pkg::rv32i_opcode_e'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    // opcode to format
    always_comb
    begin
        fmt     = rv32i_pkg::fmt_i;
        illegal = 1'b0;
        case (opcode)
            rv32i_pkg::opc_op:
            begin
                fmt = rv32i_pkg::fmt_r;
            end
            rv32i_pkg::opc_jalr,
            rv32i_pkg::opc_load,
            rv32i_pkg::opc_op_imm,
            rv32i_pkg::opc_misc_mem,
            rv32i_pkg::opc_system:
            begin
                fmt = rv32i_pkg::fmt_i;
            end
            rv32i_pkg::opc_store:
            begin
                fmt = rv32i_pkg::fmt_s;
            end
            rv32i_pkg::opc_branch:
            begin
                fmt = rv32i_pkg::fmt_b;
            end
            rv32i_pkg::opc_lui,
            rv32i_pkg::opc_auipc:
            begin
                fmt = rv32i_pkg::fmt_u;
            end
            rv32i_pkg::opc_jal:
            begin
                fmt = rv32i_pkg::fmt_j;
            end
            default:
            begin
                // unknown opcode, decoded as i-type
                illegal = 1'b1;
            end
        endcase
    end

    // immediate for the selected format, sign bit is instr_i[31]
    always_comb
    begin
        case (fmt)
            rv32i_pkg::fmt_i: imm = {{21{instr_i[31]}}, instr_i[30:20]};
            rv32i_pkg::fmt_s: imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            rv32i_pkg::fmt_b: imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                     instr_i[11:8], 1'b0};
            rv32i_pkg::fmt_u: imm = {instr_i[31:12], 12'h000};
            rv32i_pkg::fmt_j: imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                     instr_i[30:21], 1'b0};
            default:          imm = '0;
        endcase
    end

    regfile regfile_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_i       (wb_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    always_comb
    begin
        pkt_o.opcode   = opcode;
        pkt_o.funct3   = funct3;
        pkt_o.funct7   = funct7;
        pkt_o.rs1      = rs1;
        pkt_o.rs2      = rs2;
        pkt_o.rd       = rd;
        pkt_o.rs1_data = rs1_data;
        pkt_o.rs2_data = rs2_data;
        pkt_o.imm      = imm;
        pkt_o.fmt      = fmt;
        pkt_o.illegal  = illegal;
    end

endmodule : decode_stage

//--- hdl/decode_top.sv
module decode_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // instruction in
    input  logic                   in_valid_i,
    input  rv32i_pkg::rv32i_word_t in_instr_i,
    output logic                   in_ready_o,

    // register write-back from later stages
    input  rv32i_pkg::wb_t         wb_i,

    // decoded packet out
    output logic                   out_valid_o,
    output rv32i_pkg::decoded_t    out_pkt_o,
    input  logic                   out_ready_i
);

    // input buffer to decode
    logic                   ib_valid;
    rv32i_pkg::rv32i_word_t ib_instr;
    logic                   ib_ready;

    // decode to output buffer
    logic                   dec_valid;
    rv32i_pkg::decoded_t    dec_pkt;
    logic                   ob_ready;

    decode_skid_buffer #(
        .payload_t (rv32i_pkg::rv32i_word_t)
    ) in_buf_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_instr_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (ib_valid),
        .out_data_o  (ib_instr),
        .out_ready_i (ib_ready)
    );

    // operands are read while the instruction sits at the input buffer head
    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_i),
        .in_valid_i  (ib_valid),
        .instr_i     (ib_instr),
        .in_ready_o  (ib_ready),
        .out_valid_o (dec_valid),
        .pkt_o       (dec_pkt),
        .out_ready_i (ob_ready)
    );

    decode_skid_buffer #(
        .payload_t (rv32i_pkg::decoded_t)
    ) out_buf_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (dec_valid),
        .in_data_i   (dec_pkt),
        .in_ready_o  (ob_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_pkt_o),
        .out_ready_i (out_ready_i)
    );

endmodule : decode_top

//--- tb/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: instruction word, expected imm, expected format, expected illegal flag
typedef struct packed {
    rv32i_pkg::rv32i_word_t instr;
    rv32i_pkg::rv32i_word_t imm;
    rv32i_pkg::inst_fmt_e   fmt;
    logic                   illegal;
} vector_t;

localparam int NUM_VECTORS = 20;
localparam int NUM_PRELOAD = 8;

vector_t vectors [NUM_VECTORS] = '{
    '{32'h00208233, 32'h00000000, rv32i_pkg::fmt_r, 1'b0},  // add  x4, x1, x2
    '{32'h40a18fb3, 32'h00000000, rv32i_pkg::fmt_r, 1'b0},  // sub  x31, x3, x10
    '{32'h12308293, 32'h00000123, rv32i_pkg::fmt_i, 1'b0},  // addi x5, x1, 0x123
    '{32'hffc12303, 32'hfffffffc, rv32i_pkg::fmt_i, 1'b0},  // lw   x6, -4(x2)
    '{32'h02a1a523, 32'h0000002a, rv32i_pkg::fmt_s, 1'b0},  // sw   x10, 42(x3)
    '{32'hfff28823, 32'hfffffff0, rv32i_pkg::fmt_s, 1'b0},  // sb   x31, -16(x5)
    '{32'h10208063, 32'h00000100, rv32i_pkg::fmt_b, 1'b0},  // beq  x1, x2, +256
    '{32'hfea19ce3, 32'hfffffff8, rv32i_pkg::fmt_b, 1'b0},  // bne  x3, x10, -8
    '{32'h123453b7, 32'h12345000, rv32i_pkg::fmt_u, 1'b0},  // lui  x7
    '{32'hfedcb417, 32'hfedcb000, rv32i_pkg::fmt_u, 1'b0},  // auipc x8
    '{32'h001000ef, 32'h00000800, rv32i_pkg::fmt_j, 1'b0},  // jal  x1, +2048
    '{32'hffdff06f, 32'hfffffffc, rv32i_pkg::fmt_j, 1'b0},  // jal  x0, -4
    '{32'h00008067, 32'h00000000, rv32i_pkg::fmt_i, 1'b0},  // jalr x0, 0(x1)
    '{32'h00000073, 32'h00000000, rv32i_pkg::fmt_i, 1'b0},  // ecall
    '{32'h0ff0000f, 32'h000000ff, rv32i_pkg::fmt_i, 1'b0},  // fence
    '{32'h403fd493, 32'h00000403, rv32i_pkg::fmt_i, 1'b0},  // srai x9, x31, 3
    '{32'hffffffff, 32'hffffffff, rv32i_pkg::fmt_i, 1'b1},  // opcode 7f
    '{32'h0000000b, 32'h00000000, rv32i_pkg::fmt_i, 1'b1},  // custom-0
    '{32'h12300057, 32'h00000123, rv32i_pkg::fmt_i, 1'b1},  // opcode 57
    '{32'h01f005b3, 32'h00000000, rv32i_pkg::fmt_r, 1'b0}   // add  x11, x0, x31
};

// columns: load, rd, data; the x0 write must leave x0 at zero
rv32i_pkg::wb_t preloads [NUM_PRELOAD] = '{
    '{1'b1, 5'd1,  32'h11111111},
    '{1'b1, 5'd2,  32'h80000002},
    '{1'b1, 5'd3,  32'hdeadbeef},
    '{1'b1, 5'd5,  32'h00000005},
    '{1'b1, 5'd10, 32'ha5a5a5a5},
    '{1'b1, 5'd31, 32'h7fffffff},
    '{1'b1, 5'd0,  32'hffffffff},
    '{1'b1, 5'd3,  32'h0badf00d}
};

`endif

//--- tb/decode_tb.sv
module decode_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "decode_vectors.svh"

    localparam time CLK_PERIOD     = 100ns;
    localparam int  RESET_CYCLES   = 3;
    localparam int  NUM_PASSES     = 2;
    localparam int  SEED           = 32'h1528;
    localparam int  TIMEOUT_CYCLES = NUM_PASSES * NUM_VECTORS * 20 + NUM_PRELOAD
                                     + RESET_CYCLES;

    logic                   clk;
    logic                   rst_n_i;
    logic                   in_valid_i;
    rv32i_pkg::rv32i_word_t in_instr_i;
    logic                   in_ready_o;
    rv32i_pkg::wb_t         wb_i;
    logic                   out_valid_o;
    rv32i_pkg::decoded_t    out_pkt_o;
    logic                   out_ready_i;

    rv32i_pkg::rv32i_word_t reg_model [rv32i_pkg::NUM_REGS];
    int                     expected_q [$];
    int                     sent;
    int                     received;
    int                     checks;
    int                     errors;
    logic                   stall_en;

    decode_top decode_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_instr_i  (in_instr_i),
        .in_ready_o  (in_ready_o),
        .wb_i        (wb_i),
        .out_valid_o (out_valid_o),
        .out_pkt_o   (out_pkt_o),
        .out_ready_i (out_ready_i)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    // expected fields come from the fixed bit ranges and the register model
    task automatic check_packet(input int idx);
        rv32i_pkg::rv32i_word_t w;
        rv32i_pkg::decoded_t    p;
        string                  tag;
        w   = vectors[idx].instr;
        p   = out_pkt_o;
        tag = $sformatf(" (vector %0d)", idx);
        check_val({"out_pkt_o.opcode", tag}, w[6:0], p.opcode);
        check_val({"out_pkt_o.funct3", tag}, w[14:12], p.funct3);
        check_val({"out_pkt_o.funct7", tag}, w[31:25], p.funct7);
        check_val({"out_pkt_o.rs1", tag}, w[19:15], p.rs1);
        check_val({"out_pkt_o.rs2", tag}, w[24:20], p.rs2);
        check_val({"out_pkt_o.rd", tag}, w[11:7], p.rd);
        check_val({"out_pkt_o.rs1_data", tag}, reg_model[w[19:15]], p.rs1_data);
        check_val({"out_pkt_o.rs2_data", tag}, reg_model[w[24:20]], p.rs2_data);
        check_val({"out_pkt_o.imm", tag}, vectors[idx].imm, p.imm);
        check_val({"out_pkt_o.fmt", tag}, vectors[idx].fmt, p.fmt);
        check_val({"out_pkt_o.illegal", tag}, vectors[idx].illegal, p.illegal);
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_instr(input int idx);
        logic taken;
        taken = 1'b0;
        while (!taken)
        begin
            in_valid_i = 1'b1;
            in_instr_i = vectors[idx].instr;
            taken      = in_ready_o;
            if (taken)
            begin
                expected_q.push_back(idx);
                sent++;
            end
            @(negedge clk);
        end
        in_valid_i = 1'b0;
    endtask

    // output side, random low periods on out_ready_i when stalls are on
    initial
    begin
        void'($urandom(SEED));
        forever
        begin
            @(negedge clk);
            if (rst_n_i)
            begin
                out_ready_i = stall_en ? (($urandom % 4) != 0) : 1'b1;
                if (out_valid_o && out_ready_i)
                begin
                    if (expected_q.size() == 0)
                    begin
                        errors++;
                        $display("output packet arrived with no instruction waiting for it");
                    end
                    else
                    begin
                        check_packet(expected_q.pop_front());
                        received++;
                    end
                end
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d packets received",
                 TIMEOUT_CYCLES, received, sent);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_instr_i  = '0;
        wb_i        = '0;
        out_ready_i = 1'b1;
        stall_en    = 1'b0;
        sent        = 0;
        received    = 0;
        checks      = 0;
        errors      = 0;
        for (int r = 0; r < rv32i_pkg::NUM_REGS; r++)
        begin
            reg_model[r] = '0;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_val("out_valid_o after reset", 32'd0, out_valid_o);
        check_val("in_ready_o after reset", 32'd1, in_ready_o);

        // write-back preload, x0 stays zero in the model
        for (int i = 0; i < NUM_PRELOAD; i++)
        begin
            wb_i = preloads[i];
            if (preloads[i].load && preloads[i].rd != '0)
            begin
                reg_model[preloads[i].rd] = preloads[i].data;
            end
            @(negedge clk);
        end
        wb_i = '0;

        // first pass streams freely, second pass under back-pressure
        for (int pass = 0; pass < NUM_PASSES; pass++)
        begin
            stall_en = (pass != 0);
            for (int i = 0; i < NUM_VECTORS; i++)
            begin
                send_instr(i);
            end
        end
        while (received < sent)
        begin
            @(negedge clk);
        end
        stall_en = 1'b0;

        // nothing more may come out once the queue is drained
        repeat (4) @(negedge clk);
        check_val("out_valid_o after drain", 32'd0, out_valid_o);
        check_val("packets received", NUM_PASSES * NUM_VECTORS, received);

        $display("checks run: %0d, errors: %0d, packets: %0d", checks, errors, received);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : decode_tb

//--- vlog.f
+incdir+tb
hdl/rv32i_pkg.sv
hdl/decode_skid_buffer.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/decode_top.sv
tb/decode_tb.sv
